/* dv/lc3b_asserts.sv */
//**********************************************************
// Memory port checks bound into the LC-3b core
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_asserts
	import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_mem_resp,
	input  lc3b_word o_mem_addr,
	input  lc3b_word o_mem_wdata,
	input  logic     o_mem_read,
	input  logic     o_mem_write
);

	one_direction: assert property (@(posedge clk) disable iff (i_reset)
		!(o_mem_read && o_mem_write))
		else $error("memory read and write high together");

	// Request held until its response
	request_stable: assert property (@(posedge clk) disable iff (i_reset)
		((o_mem_read || o_mem_write) && !i_mem_resp) |=>
		($stable(o_mem_addr) && $stable(o_mem_wdata) &&
		$stable(o_mem_read) && $stable(o_mem_write)))
		else $error("memory request changed before its response");

	idle_after_reset: assert property (@(posedge clk)
		$past(i_reset) |-> (!o_mem_read && !o_mem_write))
		else $error("memory request active right after reset");

endmodule

`default_nettype wire

/* dv/lc3b_tb.sv */
//**********************************************************
// Testbench for the LC-3b core: memory model with random
// wait states, ISA reference model and store checks
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_tb
	import lc3b_pkg::*;
();

	localparam lc3b_word LOOP_ADDR = 16'd72;
	localparam int CYCLES_PER_INSTR = 40;
	localparam int RESET_CYCLES = 8;

	logic clk = 1'b0;
	logic reset;
	logic mem_resp = 1'b0;
	lc3b_word mem_rdata = 16'h0000;
	lc3b_word mem_addr;
	lc3b_word mem_wdata;
	logic mem_read;
	logic mem_write;

	lc3b_word image [256];
	lc3b_word mem [256];
	lc3b_word ref_addr [$];
	lc3b_word ref_data [$];
	int ref_instrs;
	int cycle_limit;
	int cycles = 0;
	int store_idx = 0;
	int loop_fetches = 0;
	logic [31:0] lfsr = 32'h663ef04c;
	logic busy = 1'b0;
	logic [1:0] wait_left = 2'd0;

	lc3b_cpu DUT
	(
		.clk(clk),
		.i_reset(reset),
		.i_mem_resp(mem_resp),
		.i_mem_rdata(mem_rdata),
		.o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write)
	);

	bind lc3b_cpu lc3b_asserts u_asserts
	(
		.clk(clk),
		.i_reset(i_reset),
		.i_mem_resp(i_mem_resp),
		.o_mem_addr(o_mem_addr),
		.o_mem_wdata(o_mem_wdata),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write)
	);

	always #2 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic lc3b_word alu_reg(input lc3b_opcode op, input int dr, input int sr1,
		input int sr2);
		return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic lc3b_word alu_imm(input lc3b_opcode op, input int dr, input int sr1,
		input int imm);
		return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word invert(input int dr, input int sr);
		return {op_not, dr[2:0], sr[2:0], 6'b111111};
	endfunction

	function automatic lc3b_word mem_op(input lc3b_opcode op, input int r, input int base,
		input int off);
		return {op, r[2:0], base[2:0], off[5:0]};
	endfunction

	function automatic lc3b_word lea(input int dr, input int off);
		return {op_lea, dr[2:0], off[8:0]};
	endfunction

	function automatic lc3b_word branch(input logic [2:0] nzp, input int off);
		return {op_br, nzp, off[8:0]};
	endfunction

	function automatic lc3b_word jump(input int base);
		return {op_jmp, 3'b000, base[2:0], 6'b000000};
	endfunction

	task automatic load_program();
		for (int i = 0; i < 256; i++)
			image[i] = {i[7:0], i[7:0] ^ 8'ha5};
		// R6 points at the data area, byte 0xC0
		image[0] = lea(6, 95);
		// ALU chains with back-to-back dependencies
		image[1] = alu_imm(op_add, 1, 0, 7);
		image[2] = alu_imm(op_add, 2, 1, -3);
		image[3] = alu_reg(op_add, 3, 1, 2);
		image[4] = alu_imm(op_and, 4, 3, 6);
		image[5] = invert(5, 3);
		image[6] = alu_reg(op_and, 7, 5, 1);
		image[7] = mem_op(op_str, 3, 6, 0);
		image[8] = mem_op(op_str, 4, 6, 1);
		image[9] = mem_op(op_str, 5, 6, 2);
		image[10] = mem_op(op_str, 7, 6, 3);
		// Load-use on both source slots
		image[11] = mem_op(op_ldr, 1, 6, 8);
		image[12] = alu_reg(op_add, 2, 1, 3);
		image[13] = mem_op(op_str, 2, 6, 4);
		image[14] = mem_op(op_ldr, 0, 6, 0);
		image[15] = mem_op(op_str, 0, 6, 5);
		// Branches on z, n and p, each taken and not taken
		image[16] = alu_imm(op_add, 1, 0, -11);
		image[17] = branch(3'b010, 1);
		image[18] = mem_op(op_str, 0, 6, 15);
		image[19] = branch(3'b101, 1);
		image[20] = mem_op(op_str, 1, 6, 6);
		image[21] = invert(2, 1);
		image[22] = branch(3'b011, 1);
		image[23] = mem_op(op_str, 2, 6, 7);
		image[24] = branch(3'b100, 1);
		image[25] = mem_op(op_str, 2, 6, 14);
		image[26] = alu_imm(op_add, 3, 0, 1);
		image[27] = branch(3'b001, 1);
		image[28] = mem_op(op_str, 3, 6, 13);
		image[29] = branch(3'b110, 1);
		image[30] = mem_op(op_str, 3, 6, 8);
		// LEA then JMP over two stores
		image[31] = lea(5, 3);
		image[32] = jump(5);
		image[33] = mem_op(op_str, 3, 6, 12);
		image[34] = mem_op(op_str, 2, 6, 11);
		image[35] = mem_op(op_str, 5, 6, 9);
		image[36] = branch(3'b111, -1);
	endtask

	function automatic lc3b_cc nzp_of(input lc3b_word v);
		if (v == 16'h0000)
			return 3'b010;
		if (v[15])
			return 3'b100;
		return 3'b001;
	endfunction

	// ISA-level run of the image; returns instructions up to the self-loop
	function automatic int ref_run();
		lc3b_word m [256];
		lc3b_word r [8];
		lc3b_cc cc;
		lc3b_word pc;
		lc3b_word ir;
		lc3b_word opnd;
		lc3b_word ea;
		lc3b_word target;
		logic done;
		int count;
		m = image;
		r = '{default: 16'h0000};
		cc = 3'b010;
		pc = LC3B_RESET_PC;
		done = 1'b0;
		count = 0;
		while (!done && count < 1000)
		begin
			ir = m[pc[8:1]];
			pc = pc + 16'd2;
			count++;
			opnd = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			ea = r[ir[8:6]] + ({{10{ir[5]}}, ir[5:0]} << 1);
			target = pc + ({{7{ir[8]}}, ir[8:0]} << 1);
			case (ir[15:12])
				op_add:
				begin
					r[ir[11:9]] = r[ir[8:6]] + opnd;
					cc = nzp_of(r[ir[11:9]]);
				end
				op_and:
				begin
					r[ir[11:9]] = r[ir[8:6]] & opnd;
					cc = nzp_of(r[ir[11:9]]);
				end
				op_not:
				begin
					r[ir[11:9]] = ~r[ir[8:6]];
					cc = nzp_of(r[ir[11:9]]);
				end
				op_lea:
					r[ir[11:9]] = target;
				op_ldr:
				begin
					r[ir[11:9]] = m[ea[8:1]];
					cc = nzp_of(r[ir[11:9]]);
				end
				op_str:
				begin
					m[ea[8:1]] = r[ir[11:9]];
					ref_addr.push_back(ea);
					ref_data.push_back(r[ir[11:9]]);
				end
				op_br:
				begin
					if ((ir[11:9] & cc) != 3'b000)
					begin
						done = (target == pc - 16'd2);
						pc = target;
					end
				end
				op_jmp:
					pc = r[ir[8:6]];
				default:
					;
			endcase
		end
		return count;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_store(input lc3b_word got_addr, input lc3b_word got_data,
		input lc3b_word exp_addr, input lc3b_word exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data)
			abort_run($sformatf("FAIL t=%0t: store %0d wrote %h at %h, expected %h at %h",
				$time, store_idx, got_data, got_addr, exp_data, exp_addr));
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("FAIL t=%0t: %0d stores seen, expected %0d", $time, got, exp));
	endtask

	// Memory model, one request at a time, 0 to 3 wait cycles
	always @(posedge clk)
	begin
		#1;
		if (reset)
		begin
			mem = image;
			mem_resp = 1'b0;
			busy = 1'b0;
		end
		else if (mem_resp)
		begin
			mem_resp = 1'b0;
			busy = 1'b0;
		end
		else
		begin
			if (!busy && (mem_read || mem_write))
			begin
				busy = 1'b1;
				lfsr = lfsr_next(lfsr);
				wait_left[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				wait_left[1] = lfsr[0];
			end
			if (busy && wait_left == 2'd0)
			begin
				if (mem_write)
					mem[mem_addr[8:1]] = mem_wdata;
				mem_rdata = mem[mem_addr[8:1]];
				mem_resp = 1'b1;
			end
			else if (busy)
				wait_left = wait_left - 2'd1;
		end
	end

	// Completed accesses are stable at the falling edge
	always @(negedge clk)
	begin
		if (!reset && mem_resp && mem_write)
		begin
			if (store_idx >= ref_addr.size())
				abort_run($sformatf("FAIL t=%0t: extra store of %h at %h",
					$time, mem_wdata, mem_addr));
			else
				check_store(mem_addr, mem_wdata, ref_addr[store_idx], ref_data[store_idx]);
			store_idx++;
		end
		if (!reset && mem_resp && mem_read && mem_addr == LOOP_ADDR)
			loop_fetches++;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
			abort_run($sformatf("Timeout: the DUT hung and never reached its final loop in %0d cycles",
				cycles));
	end

	initial
	begin
		reset = 1'b1;
		load_program();
		ref_instrs = ref_run();
		cycle_limit = CYCLES_PER_INSTR * ref_instrs + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		// Several fetches of the self-loop mean the program is done
		wait (loop_fetches >= 4);
		check_count(store_idx, ref_addr.size());
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* lc3b_cpu.f */
rtl/lc3b_pkg.sv
rtl/lc3b_stage_reg.sv
rtl/lc3b_control_rom.sv
rtl/lc3b_regfile.sv
rtl/lc3b_execute.sv
rtl/lc3b_mem_arbiter.sv
rtl/lc3b_cpu.sv
dv/lc3b_asserts.sv
dv/lc3b_tb.sv

/* rtl/lc3b_control_rom.sv */
//**********************************************************
// LC-3b decoder from instruction word to control word
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_control_rom
	import lc3b_pkg::*;
(
	input  lc3b_word i_instr,
	output lc3b_ctrl o_ctrl
);

	always_comb
	begin
		o_ctrl = '0;
		o_ctrl.opcode = lc3b_opcode'(i_instr[15:12]);
		case (lc3b_opcode'(i_instr[15:12]))
			op_add,
			op_and:
			begin
				// Bit 5 picks imm5 over SR2
				o_ctrl.sr1_needed = 1'b1;
				o_ctrl.sr2_needed = !i_instr[5];
				o_ctrl.imm_sel = i_instr[5];
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.alu_op = (i_instr[15:12] == op_add) ? alu_add : alu_and;
			end
			op_not:
			begin
				o_ctrl.sr1_needed = 1'b1;
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.alu_op = alu_not;
			end
			op_lea:
			begin
				// No CC update on LC-3b LEA
				o_ctrl.load_reg = 1'b1;
				o_ctrl.alu_op = alu_pass_addr;
			end
			op_ldr:
			begin
				o_ctrl.sr1_needed = 1'b1;
				o_ctrl.load_reg = 1'b1;
				o_ctrl.load_cc = 1'b1;
				o_ctrl.mem_read = 1'b1;
				o_ctrl.alu_op = alu_pass_addr;
				o_ctrl.wb_sel = wb_mem;
			end
			op_str:
			begin
				// SR2 slot carries the store source
				o_ctrl.sr1_needed = 1'b1;
				o_ctrl.sr2_needed = 1'b1;
				o_ctrl.mem_write = 1'b1;
				o_ctrl.alu_op = alu_pass_addr;
			end
			op_br:
				o_ctrl.is_br = 1'b1;
			op_jmp:
			begin
				o_ctrl.sr1_needed = 1'b1;
				o_ctrl.is_jmp = 1'b1;
			end
			default:
				;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/lc3b_cpu.sv */
//**********************************************************
// Five-stage LC-3b core with hazard control, condition
// codes and one shared memory port
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_cpu
	import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_mem_resp,
	input  lc3b_word i_mem_rdata,
	output lc3b_word o_mem_addr,
	output lc3b_word o_mem_wdata,
	output logic     o_mem_read,
	output logic     o_mem_write
);

	lc3b_word pc;
	lc3b_cc cc;
	logic fetch_req;
	logic fetch_resp;
	logic fetch_stale;
	logic data_req;
	logic data_resp;
	logic data_stall;
	lc3b_word mem_rdata;
	logic load_use;
	logic cc_hold;
	logic decode_hold;
	logic ex_redirect;
	logic redirect;
	lc3b_word ex_target;
	lc3b_ctrl dec_ctrl;
	lc3b_reg dec_sr2;
	lc3b_word rf_a;
	lc3b_word rf_b;
	logic wb_write;
	lc3b_word wb_data;
	logic if_id_valid;
	logic id_ex_valid;
	logic ex_mem_valid;
	logic mem_wb_valid;
	lc3b_if_id_t if_id_in;
	lc3b_if_id_t if_id;
	lc3b_id_ex_t id_ex_in;
	lc3b_id_ex_t id_ex;
	lc3b_ex_mem_t ex_mem_in;
	lc3b_ex_mem_t ex_mem;
	lc3b_mem_wb_t mem_wb_in;
	lc3b_mem_wb_t mem_wb;

	assign data_req = ex_mem_valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);
	assign data_stall = data_req && !data_resp;
	assign decode_hold = load_use || cc_hold;
	assign fetch_req = !data_stall && !decode_hold;
	assign redirect = id_ex_valid && ex_redirect && !data_stall;

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			pc <= LC3B_RESET_PC;
			fetch_stale <= 1'b0;
		end
		else
		begin
			if (redirect)
				pc <= ex_target;
			else if (fetch_resp && !fetch_stale && !decode_hold && !data_stall)
				pc <= pc + 16'd2;
			// A fetch granted before the redirect returns a wrong-path word
			if (redirect && !fetch_resp && !data_resp)
				fetch_stale <= 1'b1;
			else if (fetch_resp)
				fetch_stale <= 1'b0;
		end
	end

	lc3b_mem_arbiter u_arbiter
	(
		.clk,
		.i_reset,
		.i_fetch_req(fetch_req),
		.i_fetch_addr(pc),
		.i_data_req(data_req),
		.i_data_write(ex_mem.ctrl.mem_write),
		.i_data_addr(ex_mem.result),
		.i_data_wdata(ex_mem.store_data),
		.i_mem_resp,
		.i_mem_rdata,
		.o_fetch_resp(fetch_resp),
		.o_data_resp(data_resp),
		.o_rdata(mem_rdata),
		.o_mem_addr,
		.o_mem_wdata,
		.o_mem_read,
		.o_mem_write
	);

	assign if_id_in.pc_plus2 = pc + 16'd2;
	assign if_id_in.instr = mem_rdata;

	lc3b_stage_reg #(.payload_t(lc3b_if_id_t)) u_if_id
	(
		.clk,
		.i_reset,
		.i_enable(!data_stall && !decode_hold),
		.i_flush(redirect),
		.i_valid(fetch_resp && !fetch_stale),
		.i_data(if_id_in),
		.o_valid(if_id_valid),
		.o_data(if_id)
	);

	lc3b_control_rom u_control_rom
	(
		.i_instr(if_id.instr),
		.o_ctrl(dec_ctrl)
	);

	// STR reads its source through the second port
	assign dec_sr2 = dec_ctrl.mem_write ? if_id.instr[11:9] : if_id.instr[2:0];

	lc3b_regfile u_regfile
	(
		.clk,
		.i_reset,
		.i_write(wb_write),
		.i_dest(mem_wb.dest),
		.i_wdata(wb_data),
		.i_src_a(if_id.instr[8:6]),
		.i_src_b(dec_sr2),
		.o_rdata_a(rf_a),
		.o_rdata_b(rf_b)
	);

	assign load_use = if_id_valid && id_ex_valid && id_ex.ctrl.mem_read &&
		((dec_ctrl.sr1_needed && if_id.instr[8:6] == id_ex.dest) ||
		(dec_ctrl.sr2_needed && dec_sr2 == id_ex.dest));

	// BR waits until every older CC writer has retired
	assign cc_hold = if_id_valid && dec_ctrl.is_br &&
		((id_ex_valid && id_ex.ctrl.load_cc) ||
		(ex_mem_valid && ex_mem.ctrl.load_cc) ||
		(mem_wb_valid && mem_wb.ctrl.load_cc));

	always_comb
	begin
		id_ex_in.ctrl = dec_ctrl;
		id_ex_in.pc_plus2 = if_id.pc_plus2;
		id_ex_in.instr = if_id.instr;
		id_ex_in.sr1_val = rf_a;
		id_ex_in.sr2_val = rf_b;
		id_ex_in.sr1 = if_id.instr[8:6];
		id_ex_in.sr2 = dec_sr2;
		id_ex_in.dest = if_id.instr[11:9];
	end

	lc3b_stage_reg #(.payload_t(lc3b_id_ex_t)) u_id_ex
	(
		.clk,
		.i_reset,
		.i_enable(!data_stall),
		.i_flush(redirect),
		.i_valid(if_id_valid && !decode_hold),
		.i_data(id_ex_in),
		.o_valid(id_ex_valid),
		.o_data(id_ex)
	);

	lc3b_execute u_execute
	(
		.i_id_ex(id_ex),
		.i_cc(cc),
		.i_ex_mem_valid(ex_mem_valid),
		.i_ex_mem(ex_mem),
		.i_wb_valid(wb_write),
		.i_wb_dest(mem_wb.dest),
		.i_wb_data(wb_data),
		.o_ex_mem(ex_mem_in),
		.o_redirect(ex_redirect),
		.o_target(ex_target)
	);

	lc3b_stage_reg #(.payload_t(lc3b_ex_mem_t)) u_ex_mem
	(
		.clk,
		.i_reset,
		.i_enable(!data_stall),
		.i_flush(1'b0),
		.i_valid(id_ex_valid),
		.i_data(ex_mem_in),
		.o_valid(ex_mem_valid),
		.o_data(ex_mem)
	);

	always_comb
	begin
		mem_wb_in.ctrl = ex_mem.ctrl;
		mem_wb_in.result = ex_mem.result;
		mem_wb_in.load_data = mem_rdata;
		mem_wb_in.dest = ex_mem.dest;
	end

	lc3b_stage_reg #(.payload_t(lc3b_mem_wb_t)) u_mem_wb
	(
		.clk,
		.i_reset,
		.i_enable(!data_stall),
		.i_flush(1'b0),
		.i_valid(ex_mem_valid),
		.i_data(mem_wb_in),
		.o_valid(mem_wb_valid),
		.o_data(mem_wb)
	);

	assign wb_data = (mem_wb.ctrl.wb_sel == wb_mem) ? mem_wb.load_data : mem_wb.result;
	assign wb_write = mem_wb_valid && mem_wb.ctrl.load_reg;

	// Reset value is z
	always_ff @(posedge clk)
	begin
		if (i_reset)
			cc <= 3'b010;
		else if (mem_wb_valid && mem_wb.ctrl.load_cc)
			cc <= {wb_data[15], wb_data == 16'd0, !wb_data[15] && wb_data != 16'd0};
	end

endmodule

`default_nettype wire

/* rtl/lc3b_execute.sv */
//**********************************************************
// Execute stage: forwarding, ALU, address adder and
// branch or jump resolution
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_execute
	import lc3b_pkg::*;
(
	input  lc3b_id_ex_t  i_id_ex,
	input  lc3b_cc       i_cc,
	input  logic         i_ex_mem_valid,
	input  lc3b_ex_mem_t i_ex_mem,
	input  logic         i_wb_valid,
	input  lc3b_reg      i_wb_dest,
	input  lc3b_word     i_wb_data,
	output lc3b_ex_mem_t o_ex_mem,
	output logic         o_redirect,
	output lc3b_word     o_target
);

	lc3b_ctrl ctrl;
	logic mem_fwd;
	lc3b_word src_a;
	lc3b_word src_b;
	lc3b_word operand_b;
	lc3b_word imm5;
	lc3b_word pc_offset;
	lc3b_word base_offset;
	lc3b_word addr;
	lc3b_word alu_out;

	// Load data is not back yet while the load sits in EX/MEM
	assign mem_fwd = i_ex_mem_valid && i_ex_mem.ctrl.load_reg && !i_ex_mem.ctrl.mem_read;

	function automatic lc3b_word forward(input lc3b_reg src, input lc3b_word reg_value);
		if (mem_fwd && i_ex_mem.dest == src)
			return i_ex_mem.result;
		if (i_wb_valid && i_wb_dest == src)
			return i_wb_data;
		return reg_value;
	endfunction

	assign ctrl = i_id_ex.ctrl;

	always_comb
	begin
		src_a = forward(i_id_ex.sr1, i_id_ex.sr1_val);
		src_b = forward(i_id_ex.sr2, i_id_ex.sr2_val);
	end

	assign imm5 = {{11{i_id_ex.instr[4]}}, i_id_ex.instr[4:0]};
	assign pc_offset = {{6{i_id_ex.instr[8]}}, i_id_ex.instr[8:0], 1'b0};
	assign base_offset = {{9{i_id_ex.instr[5]}}, i_id_ex.instr[5:0], 1'b0};
	assign operand_b = ctrl.imm_sel ? imm5 : src_b;

	// LDR and STR are base-relative, LEA and BR are PC-relative
	assign addr = (ctrl.opcode == op_ldr || ctrl.opcode == op_str) ?
		src_a + base_offset : i_id_ex.pc_plus2 + pc_offset;

	always_comb
	begin
		case (ctrl.alu_op)
			alu_add:
				alu_out = src_a + operand_b;
			alu_and:
				alu_out = src_a & operand_b;
			alu_not:
				alu_out = ~src_a;
			default:
				alu_out = addr;
		endcase
	end

	always_comb
	begin
		o_ex_mem.ctrl = ctrl;
		o_ex_mem.result = alu_out;
		o_ex_mem.store_data = src_b;
		o_ex_mem.dest = i_id_ex.dest;
	end

	assign o_redirect = ctrl.is_jmp || (ctrl.is_br && |(i_id_ex.instr[11:9] & i_cc));
	assign o_target = ctrl.is_jmp ? src_a : addr;

endmodule

`default_nettype wire

/* rtl/lc3b_mem_arbiter.sv */
//**********************************************************
// Shares the memory port between fetch and data, data first
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_mem_arbiter
	import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_fetch_req,
	input  lc3b_word i_fetch_addr,
	input  logic     i_data_req,
	input  logic     i_data_write,
	input  lc3b_word i_data_addr,
	input  lc3b_word i_data_wdata,
	input  logic     i_mem_resp,
	input  lc3b_word i_mem_rdata,
	output logic     o_fetch_resp,
	output logic     o_data_resp,
	output lc3b_word o_rdata,
	output lc3b_word o_mem_addr,
	output lc3b_word o_mem_wdata,
	output logic     o_mem_read,
	output logic     o_mem_write
);

	typedef enum logic [1:0]
	{
		owner_idle,
		owner_fetch,
		owner_data
	} owner_t;

	owner_t owner;
	logic write_q;

	always_ff @(posedge clk)
	begin
		if (i_reset)
			owner <= owner_idle;
		else if (owner == owner_idle)
		begin
			if (i_data_req)
				owner <= owner_data;
			else if (i_fetch_req)
				owner <= owner_fetch;
		end
		else if (i_mem_resp)
			owner <= owner_idle;
	end

	// Request is captured at grant and held until its response
	always_ff @(posedge clk)
	begin
		if (owner == owner_idle)
		begin
			write_q <= i_data_req && i_data_write;
			o_mem_addr <= i_data_req ? i_data_addr : i_fetch_addr;
			o_mem_wdata <= i_data_wdata;
		end
	end

	assign o_mem_read = (owner == owner_fetch) || (owner == owner_data && !write_q);
	assign o_mem_write = (owner == owner_data) && write_q;

	assign o_fetch_resp = (owner == owner_fetch) && i_mem_resp;
	assign o_data_resp = (owner == owner_data) && i_mem_resp;
	assign o_rdata = i_mem_rdata;

endmodule

`default_nettype wire

/* rtl/lc3b_pkg.sv */
//**********************************************************
// LC-3b shared types: words, opcodes, control word and the
// payloads carried between the pipeline stages
//**********************************************************
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Order is n, z, p
	typedef logic [2:0] lc3b_cc;

	localparam int LC3B_NUM_REGS = 8;
	localparam lc3b_word LC3B_RESET_PC = 16'h0000;

	typedef enum logic [3:0]
	{
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_jmp = 4'b1100,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0]
	{
		alu_add,
		alu_and,
		alu_not,
		alu_pass_addr
	} lc3b_alu_op;

	typedef enum logic
	{
		wb_alu,
		wb_mem
	} lc3b_wb_sel;

	typedef struct packed
	{
		lc3b_opcode opcode;
		logic sr1_needed;
		logic sr2_needed;
		logic imm_sel;
		logic load_reg;
		logic load_cc;
		logic mem_read;
		logic mem_write;
		logic is_br;
		logic is_jmp;
		lc3b_alu_op alu_op;
		lc3b_wb_sel wb_sel;
	} lc3b_ctrl;

	typedef struct packed
	{
		lc3b_word pc_plus2;
		lc3b_word instr;
	} lc3b_if_id_t;

	typedef struct packed
	{
		lc3b_ctrl ctrl;
		lc3b_word pc_plus2;
		lc3b_word instr;
		lc3b_word sr1_val;
		lc3b_word sr2_val;
		lc3b_reg sr1;
		lc3b_reg sr2;
		lc3b_reg dest;
	} lc3b_id_ex_t;

	// Result is the ALU value or the memory address
	typedef struct packed
	{
		lc3b_ctrl ctrl;
		lc3b_word result;
		lc3b_word store_data;
		lc3b_reg dest;
	} lc3b_ex_mem_t;

	typedef struct packed
	{
		lc3b_ctrl ctrl;
		lc3b_word result;
		lc3b_word load_data;
		lc3b_reg dest;
	} lc3b_mem_wb_t;

endpackage

`default_nettype wire

/* rtl/lc3b_regfile.sv */
//**********************************************************
// Eight-entry register file, two read ports, write-through
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_regfile
	import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_write,
	input  lc3b_reg  i_dest,
	input  lc3b_word i_wdata,
	input  lc3b_reg  i_src_a,
	input  lc3b_reg  i_src_b,
	output lc3b_word o_rdata_a,
	output lc3b_word o_rdata_b
);

	lc3b_word regs [LC3B_NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			for (int i = 0; i < LC3B_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (i_write)
			regs[i_dest] <= i_wdata;
	end

	// Same-cycle write is visible to decode
	assign o_rdata_a = (i_write && i_dest == i_src_a) ? i_wdata : regs[i_src_a];
	assign o_rdata_b = (i_write && i_dest == i_src_b) ? i_wdata : regs[i_src_b];

endmodule

`default_nettype wire

/* rtl/lc3b_stage_reg.sv */
//**********************************************************
// Pipeline stage register with valid bit, stall and flush
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module lc3b_stage_reg
#(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_enable,
	input  logic     i_flush,
	input  logic     i_valid,
	input  payload_t i_data,
	output logic     o_valid,
	output payload_t o_data
);

	// Flush wins over a load of the next valid bit
	always_ff @(posedge clk)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (i_flush)
			o_valid <= 1'b0;
		else if (i_enable)
			o_valid <= i_valid;
	end

	always_ff @(posedge clk)
	begin
		if (i_enable)
			o_data <= i_data;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# Build the LC-3b testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module lc3b_tb -f lc3b_cpu.f \
	-o lc3b_sim > build.log 2>&1 \
	&& ./obj_dir/lc3b_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "RUN FAILED"; exit 1; }
cat sim.log
grep -q "^all tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
